// File: hw/lcd_status_cfg.svh
`ifndef LCD_STATUS_CFG_SVH
`define LCD_STATUS_CFG_SVH

// transport codes, status bits 15..12
`define LCD_CODE_NONE    4'd0
`define LCD_CODE_PLAY    4'd1
`define LCD_CODE_PAUSE   4'd2
`define LCD_CODE_STOP    4'd3
`define LCD_CODE_RECORD  4'd4

// speed modes, code 3 shows like normal
`define LCD_MODE_NORMAL  2'd0
`define LCD_MODE_SLOW    2'd1
`define LCD_MODE_FAST    2'd2

`define LCD_LINE1_BASE   8'h40
`define LCD_LINE0_CELLS  16
`define LCD_NUM_CELLS    20
`define LCD_CELL_W       5

`define LCD_ASCII_ZERO   8'h30
`define LCD_ASCII_SPACE  8'h20
`define LCD_ASCII_COLON  8'h3a
`define LCD_ASCII_SLASH  8'h2f

`define LCD_GLYPH_SLOW   8'h2f
`define LCD_GLYPH_FAST   8'h2a
`define LCD_GLYPH_INTERP 8'h40

`endif

// File: hw/lcd_status_pkg.sv
package lcd_status_pkg;

    // status word from the transport controller
    typedef struct packed {
        logic [3:0] code;       // transport code
        logic [1:0] mode;       // speed mode
        logic [3:0] speed;      // speed digit, bcd
        logic       interp;     // interpolation on
        logic [4:0] spare;
    } status_word_t;

    // time as four bcd digits
    typedef struct packed {
        logic [3:0] min_ten;
        logic [3:0] min_one;
        logic [3:0] sec_ten;
        logic [3:0] sec_one;
    } mmss_t;

    // same digits, already ascii
    typedef struct packed {
        logic [7:0] min_ten;
        logic [7:0] min_one;
        logic [7:0] sec_ten;
        logic [7:0] sec_one;
    } mmss_ascii_t;

    // everything the composer needs for one refresh
    typedef struct packed {
        logic [3:0]  code;
        logic [1:0]  mode;
        logic [7:0]  speed_char;  // ascii
        logic        interp;
        mmss_ascii_t play;
        mmss_ascii_t total;
    } frame_desc_t;

    // one write to the LCD controller
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] character;
    } lcd_cmd_t;

endpackage

// File: hw/frame_snapshot.sv
`include "lcd_status_cfg.svh"

module frame_snapshot
    import lcd_status_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         capture,
    input  status_word_t status,
    input  mmss_t        play_time,
    input  mmss_t        total_time,
    output frame_desc_t  frame_desc
);

    localparam mmss_ascii_t ZERO_TIME = {4{`LCD_ASCII_ZERO}};

    function automatic logic [7:0] bcd_to_ascii(input logic [3:0] digit);
        return `LCD_ASCII_ZERO + {4'h0, digit};
    endfunction

    function automatic mmss_ascii_t mmss_to_ascii(input mmss_t t);
        mmss_ascii_t a;
        a.min_ten = bcd_to_ascii(t.min_ten);
        a.min_one = bcd_to_ascii(t.min_one);
        a.sec_ten = bcd_to_ascii(t.sec_ten);
        a.sec_one = bcd_to_ascii(t.sec_one);
        return a;
    endfunction

    frame_desc_t next_desc;

    // conversion happens before the register so the composer sees ascii
    always_comb begin
        next_desc.code       = status.code;
        next_desc.mode       = status.mode;
        next_desc.speed_char = bcd_to_ascii(status.speed);
        next_desc.interp     = status.interp;
        next_desc.play       = mmss_to_ascii(play_time);
        next_desc.total      = mmss_to_ascii(total_time);
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            frame_desc.code       <= `LCD_CODE_NONE;
            frame_desc.mode       <= `LCD_MODE_NORMAL;
            frame_desc.speed_char <= `LCD_ASCII_ZERO;
            frame_desc.interp     <= 1'b0;
            frame_desc.play       <= ZERO_TIME;
            frame_desc.total      <= ZERO_TIME;
        end else if (capture) begin
            frame_desc <= next_desc;  // held for the whole refresh
        end
    end

endmodule

// File: hw/screen_composer.sv
`include "lcd_status_cfg.svh"

module screen_composer
    import lcd_status_pkg::*;
(
    input  logic [`LCD_CELL_W-1:0] cell_idx,
    input  frame_desc_t            frame_desc,
    output lcd_cmd_t               cell_cmd,
    output logic                   cell_write
);

    // labels left aligned in nine characters
    localparam logic [71:0] LBL_IDLE   = "Idle...  ";
    localparam logic [71:0] LBL_PLAY   = "Play     ";
    localparam logic [71:0] LBL_PAUSE  = "Pause    ";
    localparam logic [71:0] LBL_STOP   = "Stop     ";
    localparam logic [71:0] LBL_RECORD = "Recording";

    localparam logic [`LCD_CELL_W-1:0] FIRST_LINE1 = `LCD_CELL_W'(`LCD_LINE0_CELLS);

    function automatic logic [7:0] label_char(input logic [71:0] txt, input logic [3:0] col);
        logic [71:0] shifted;
        shifted = txt << {col, 3'b000};
        return shifted[71:64];
    endfunction

    // mm:ss at pos 0..4
    function automatic logic [7:0] time_char(input mmss_ascii_t t, input logic [3:0] pos);
        case (pos)
            4'd0:    return t.min_ten;
            4'd1:    return t.min_one;
            4'd2:    return `LCD_ASCII_COLON;
            4'd3:    return t.sec_ten;
            default: return t.sec_one;
        endcase
    endfunction

    logic [3:0] col;
    logic [1:0] pos1;
    logic       on_line1;
    logic       mode_shown;
    logic       line0_write;
    logic [7:0] line0_char;
    logic       line1_write;
    logic [7:0] line1_char;

    assign col        = cell_idx[3:0];
    assign pos1       = cell_idx[1:0];
    assign on_line1   = (cell_idx >= FIRST_LINE1);
    assign mode_shown = (frame_desc.mode == `LCD_MODE_SLOW) ||
                        (frame_desc.mode == `LCD_MODE_FAST);

    always_comb begin
        line0_write = 1'b0;
        line0_char  = `LCD_ASCII_SPACE;
        case (frame_desc.code)
            `LCD_CODE_NONE: begin
                line0_write = (col <= 4'd6);
                line0_char  = label_char(LBL_IDLE, col);
            end
            `LCD_CODE_PLAY: begin
                if (col <= 4'd3) begin
                    line0_write = 1'b1;
                    line0_char  = label_char(LBL_PLAY, col);
                end else if (col >= 4'd5 && col <= 4'd9) begin
                    line0_write = 1'b1;
                    line0_char  = time_char(frame_desc.play, col - 4'd5);
                end else if (col == 4'd10) begin
                    line0_write = 1'b1;
                    line0_char  = `LCD_ASCII_SLASH;
                end else if (col >= 4'd11) begin
                    line0_write = 1'b1;
                    line0_char  = time_char(frame_desc.total, col - 4'd11);
                end
            end
            `LCD_CODE_PAUSE: begin
                line0_write = (col <= 4'd4);
                line0_char  = label_char(LBL_PAUSE, col);
            end
            `LCD_CODE_STOP: begin
                line0_write = (col <= 4'd3);
                line0_char  = label_char(LBL_STOP, col);
            end
            `LCD_CODE_RECORD: begin
                if (col <= 4'd8) begin
                    line0_write = 1'b1;
                    line0_char  = label_char(LBL_RECORD, col);
                end else if (col >= 4'd11) begin
                    line0_write = 1'b1;
                    line0_char  = time_char(frame_desc.total, col - 4'd11);
                end
            end
            default: ;  // unknown code leaves line 0 blank
        endcase
    end

    always_comb begin
        line1_write = mode_shown;
        line1_char  = `LCD_ASCII_SPACE;
        case (pos1)
            2'd0: line1_char = (frame_desc.mode == `LCD_MODE_FAST) ? `LCD_GLYPH_FAST
                                                                   : `LCD_GLYPH_SLOW;
            2'd1: line1_char = frame_desc.speed_char;
            2'd2: line1_char = `LCD_ASCII_SPACE;
            default: begin
                line1_write = 1'b1;  // interp cell always written
                line1_char  = frame_desc.interp ? `LCD_GLYPH_INTERP : `LCD_ASCII_ZERO;
            end
        endcase
    end

    always_comb begin
        if (on_line1) begin
            cell_write         = line1_write;
            cell_cmd.addr      = `LCD_LINE1_BASE | {6'd0, pos1};
            cell_cmd.character = line1_char;
        end else begin
            cell_write         = line0_write;
            cell_cmd.addr      = {4'h0, col};
            cell_cmd.character = line0_char;
        end
    end

endmodule

// File: hw/lcd_sequencer.sv
`include "lcd_status_cfg.svh"

module lcd_sequencer
    import lcd_status_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   busy,
    input  lcd_cmd_t               cell_cmd,
    input  logic                   cell_write,
    output logic [`LCD_CELL_W-1:0] cell_idx,
    output lcd_cmd_t               lcd_cmd,
    output logic                   lcd_start,
    output logic                   lcd_clear
);

    localparam logic [`LCD_CELL_W-1:0] LAST_CELL = `LCD_CELL_W'(`LCD_NUM_CELLS - 1);

    typedef enum logic {
        ST_CLEAR,
        ST_WRITE
    } seq_state_t;

    seq_state_t state;
    logic       gap;        // strobe went out last cycle
    logic       ready;
    logic       last_cell;
    logic       issue_write;

    // controller flags busy one cycle late, so a strobe always costs an idle cycle
    assign ready       = !busy && !gap;
    assign last_cell   = (cell_idx == LAST_CELL);
    assign issue_write = (state == ST_WRITE) && ready && cell_write;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state     <= ST_CLEAR;
            cell_idx  <= '0;
            gap       <= 1'b0;
            lcd_start <= 1'b0;
            lcd_clear <= 1'b0;
        end else begin
            lcd_start <= 1'b0;
            lcd_clear <= 1'b0;
            gap       <= 1'b0;
            case (state)
                ST_CLEAR: begin
                    if (ready) begin
                        lcd_clear <= 1'b1;  // also the snapshot strobe
                        gap       <= 1'b1;
                        cell_idx  <= '0;
                        state     <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (ready) begin
                        if (cell_write) begin
                            lcd_start <= 1'b1;
                            gap       <= 1'b1;
                        end
                        // unwritten cells are skipped without a strobe
                        if (last_cell) begin
                            cell_idx <= '0;
                            state    <= ST_CLEAR;
                        end else begin
                            cell_idx <= cell_idx + 1'b1;
                        end
                    end
                end
                default: state <= ST_CLEAR;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue_write) begin
            lcd_cmd <= cell_cmd;  // held until next start
        end
    end

endmodule

// File: hw/lcd_status_top.sv
`include "lcd_status_cfg.svh"

module lcd_status_top
    import lcd_status_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    input  status_word_t status,
    input  mmss_t        play_time,
    input  mmss_t        total_time,
    input  logic         busy,
    output lcd_cmd_t     lcd_cmd,
    output logic         lcd_start,
    output logic         lcd_clear
);

    frame_desc_t            frame_desc;
    logic [`LCD_CELL_W-1:0] cell_idx;
    lcd_cmd_t               cell_cmd;
    logic                   cell_write;

    frame_snapshot snapshot_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .capture    (lcd_clear),
        .status     (status),
        .play_time  (play_time),
        .total_time (total_time),
        .frame_desc (frame_desc)
    );

    screen_composer composer_i (
        .cell_idx   (cell_idx),
        .frame_desc (frame_desc),
        .cell_cmd   (cell_cmd),
        .cell_write (cell_write)
    );

    lcd_sequencer sequencer_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .busy       (busy),
        .cell_cmd   (cell_cmd),
        .cell_write (cell_write),
        .cell_idx   (cell_idx),
        .lcd_cmd    (lcd_cmd),
        .lcd_start  (lcd_start),
        .lcd_clear  (lcd_clear)
    );

endmodule

// File: testbench/tb_checker.sv
`include "lcd_status_cfg.svh"

module tb_checker
    import lcd_status_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    input  status_word_t status,
    input  mmss_t        play_time,
    input  mmss_t        total_time,
    input  logic         busy,
    input  lcd_cmd_t     lcd_cmd,
    input  logic         lcd_start,
    input  logic         lcd_clear,
    output int           value_errors,
    output int           protocol_errors,
    output int           refreshes
);
    timeunit 1ns;
    timeprecision 1ps;

    lcd_cmd_t expected_q[$];    // cells still due in this refresh
    int       value_count = 0;
    int       protocol_count = 0;
    int       clear_count = 0;
    logic     prev_busy = 1'b0;
    logic     prev_strobe = 1'b0;

    assign value_errors    = value_count;
    assign protocol_errors = protocol_count;
    assign refreshes       = clear_count;

    function automatic logic [7:0] digit_char(input logic [3:0] d);
        return 8'h30 + {4'h0, d};
    endfunction

    task automatic push_cell(input logic [7:0] addr, input logic [7:0] ch);
        lcd_cmd_t c;
        c.addr      = addr;
        c.character = ch;
        expected_q.push_back(c);
    endtask

    task automatic push_text(input logic [7:0] addr, input string txt);
        for (int i = 0; i < txt.len(); i++) begin
            push_cell(addr + 8'(i), txt[i]);
        end
    endtask

    // mm:ss over five cells
    task automatic push_time(input logic [7:0] addr, input mmss_t t);
        push_cell(addr, digit_char(t.min_ten));
        push_cell(addr + 8'd1, digit_char(t.min_one));
        push_cell(addr + 8'd2, 8'h3a);
        push_cell(addr + 8'd3, digit_char(t.sec_ten));
        push_cell(addr + 8'd4, digit_char(t.sec_one));
    endtask

    task automatic build_frame(input status_word_t s, input mmss_t p, input mmss_t t);
        expected_q.delete();
        case (s.code)
            `LCD_CODE_NONE:  push_text(8'h00, "Idle...");
            `LCD_CODE_PLAY: begin
                push_text(8'h00, "Play");
                push_time(8'h05, p);
                push_cell(8'h0a, 8'h2f);  // '/'
                push_time(8'h0b, t);
            end
            `LCD_CODE_PAUSE: push_text(8'h00, "Pause");
            `LCD_CODE_STOP:  push_text(8'h00, "Stop");
            `LCD_CODE_RECORD: begin
                push_text(8'h00, "Recording");
                push_time(8'h0b, t);
            end
            default: ;  // blank line 0
        endcase
        if (s.mode == `LCD_MODE_SLOW || s.mode == `LCD_MODE_FAST) begin
            push_cell(`LCD_LINE1_BASE, (s.mode == `LCD_MODE_FAST) ? 8'h2a : 8'h2f);
            push_cell(`LCD_LINE1_BASE + 8'd1, digit_char(s.speed));
            push_cell(`LCD_LINE1_BASE + 8'd2, 8'h20);
        end
        push_cell(`LCD_LINE1_BASE + 8'd3, s.interp ? 8'h40 : 8'h30);
    endtask

    task automatic value_mismatch(input string name, input logic [7:0] expected,
                                  input logic [7:0] actual);
        $display("CHECK FAILED at %0t: %s expected 0x%h actual 0x%h",
                 $time, name, expected, actual);
        value_count++;
    endtask

    task automatic protocol_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        protocol_count++;
    endtask

    always @(posedge i_clk) begin : check_edge
        lcd_cmd_t exp;
        if (i_rst) begin
            if (lcd_start || lcd_clear) protocol_error("strobe seen during reset");
            prev_busy   = 1'b0;
            prev_strobe = 1'b0;
        end else begin
            if (lcd_start && lcd_clear) protocol_error("lcd_start and lcd_clear together");
            if ((lcd_start || lcd_clear) && prev_busy)
                protocol_error("strobe issued although busy was high");
            if ((lcd_start || lcd_clear) && prev_strobe)
                protocol_error("strobe right after another strobe");
            if (lcd_clear) begin
                if (clear_count > 0 && expected_q.size() != 0)
                    protocol_error($sformatf("refresh %0d ended with %0d cells not written",
                                             clear_count, expected_q.size()));
                build_frame(status, play_time, total_time);  // snapshot at the clear
                clear_count <= clear_count + 1;
            end
            if (lcd_start && !lcd_clear) begin
                if (clear_count == 0) begin
                    protocol_error("lcd_start before the first lcd_clear");
                end else if (expected_q.size() == 0) begin
                    protocol_error("lcd_start with no cell left in this refresh");
                end else begin
                    exp = expected_q.pop_front();
                    if (lcd_cmd.addr !== exp.addr)
                        value_mismatch("lcd_cmd.addr", exp.addr, lcd_cmd.addr);
                    if (lcd_cmd.character !== exp.character)
                        value_mismatch("lcd_cmd.character", exp.character, lcd_cmd.character);
                end
            end
            prev_busy   = busy;
            prev_strobe = lcd_start || lcd_clear;
        end
    end

endmodule

// File: testbench/tb_top.sv
module tb_top
    import lcd_status_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int REFRESH_RUNS  = 60;
    localparam int CLEAR_TIMEOUT = 2000;

    logic         i_clk;
    logic         i_rst;
    status_word_t status;
    mmss_t        play_time;
    mmss_t        total_time;
    logic         busy;
    lcd_cmd_t     lcd_cmd;
    logic         lcd_start;
    logic         lcd_clear;
    int           value_errors;
    int           protocol_errors;
    int           refreshes;

    lcd_status_top dut_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .status     (status),
        .play_time  (play_time),
        .total_time (total_time),
        .busy       (busy),
        .lcd_cmd    (lcd_cmd),
        .lcd_start  (lcd_start),
        .lcd_clear  (lcd_clear)
    );

    tb_checker checker_i (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .status          (status),
        .play_time       (play_time),
        .total_time      (total_time),
        .busy            (busy),
        .lcd_cmd         (lcd_cmd),
        .lcd_start       (lcd_start),
        .lcd_clear       (lcd_clear),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .refreshes       (refreshes)
    );

    function automatic status_word_t random_status();
        status_word_t s;
        s.code   = 4'($urandom_range(0, 5));  // 5 is an unknown code
        s.mode   = 2'($urandom_range(0, 3));
        s.speed  = 4'($urandom_range(0, 9));
        s.interp = 1'($urandom_range(0, 1));
        s.spare  = 5'($urandom_range(0, 31));
        return s;
    endfunction

    function automatic mmss_t random_mmss();
        mmss_t t;
        t.min_ten = 4'($urandom_range(0, 9));
        t.min_one = 4'($urandom_range(0, 9));
        t.sec_ten = 4'($urandom_range(0, 5));
        t.sec_one = 4'($urandom_range(0, 9));
        return t;
    endfunction

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // inputs and the LCD controller's busy line
    initial begin : stimulus
        int   status_wait;
        int   time_wait;
        int   busy_left;
        logic strobe_seen;
        void'($urandom(32'h21d88227));
        i_rst       = 1'b1;
        status      = '0;
        play_time   = '0;
        total_time  = '0;
        busy        = 1'b0;
        status_wait = 1;
        time_wait   = 1;
        busy_left   = 0;
        repeat (3) @(posedge i_clk);
        #2;
        i_rst = 1'b0;
        forever begin
            @(posedge i_clk);
            strobe_seen = lcd_start || lcd_clear;
            #2;
            status_wait--;
            if (status_wait == 0) begin
                status      = random_status();
                status_wait = $urandom_range(1, 40);
            end
            time_wait--;
            if (time_wait == 0) begin
                play_time  = random_mmss();
                total_time = random_mmss();
                time_wait  = $urandom_range(1, 40);
            end
            if (busy_left > 0) busy_left--;
            if (strobe_seen) begin
                busy_left = $urandom_range(1, 6);
            end else if (busy_left == 0 && $urandom_range(0, 15) == 0) begin
                busy_left = $urandom_range(1, 6);  // controller busy on its own
            end
            busy = (busy_left > 0);
        end
    end

    initial begin : run_control
        int waited;
        bit timed_out;
        timed_out = 1'b0;
        repeat (4) @(posedge i_clk);
        // one extra clear closes the last checked refresh
        for (int n = 1; n <= REFRESH_RUNS + 1 && !timed_out; n++) begin
            waited = 0;
            while (refreshes < n && waited < CLEAR_TIMEOUT) begin
                @(posedge i_clk);
                waited++;
            end
            if (refreshes < n) begin
                $display("timeout: no lcd_clear within %0d cycles while waiting for refresh %0d",
                         CLEAR_TIMEOUT, n);
                timed_out = 1'b1;
            end
        end
        @(negedge i_clk);
        $display("closing: %0d value errors, %0d protocol errors, %0d refreshes checked",
                 value_errors, protocol_errors, (refreshes > 0) ? refreshes - 1 : 0);
        if (timed_out || value_errors != 0 || protocol_errors != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

// File: lcd_status.f
+incdir+hw
hw/lcd_status_pkg.sv
hw/frame_snapshot.sv
hw/screen_composer.sv
hw/lcd_sequencer.sv
hw/lcd_status_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_top \
    -f lcd_status.f \
    -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "^Regression passed$" sim.log; then
    echo "simulation result: pass"
    exit 0
fi
echo "simulation result: fail"
exit 1
